// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bch_syn_tb
RTL_TOP   ?= bch_syn_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+tb
source/bch_pkg.sv
source/bch_syn_ctrl.sv
source/bch_syn_lfsr.sv
source/bch_syn_eval.sv
source/bch_syn_shuffle.sv
source/bch_syn_top.sv
tb/bch_syn_tb.sv

// ==== source/bch_pkg.sv ====
package bch_pkg;

	// field and code sizes for BCH(15,7) over GF(16).
	localparam int GF_M    = 4;
	localparam int CODE_N  = 15;
	localparam int CODE_T  = 2;
	localparam int SYN_NUM = 2 * CODE_T;
	localparam int MIN_NUM = 2;
	localparam int CNT_W   = 4;

	// one element of GF(2^4), bit k is the coefficient of alpha^k.
	typedef logic [GF_M-1:0] gf_elem_t;

	// polynomials stored without their leading x^4 term.
	// x^4+x+1.
	localparam gf_elem_t PRIM_POLY  = 4'b0011;
	localparam gf_elem_t MIN_POLY_1 = PRIM_POLY;
	// x^4+x^3+x^2+x+1.
	localparam gf_elem_t MIN_POLY_3 = 4'b1111;

	// evaluation matrices, column k is beta^k for the evaluation point beta.
	// column 0 sits in the lowest nibble.
	// beta = alpha, so this is the identity.
	localparam logic [GF_M*GF_M-1:0] EVAL_MAT_1 = {
		4'b1000, 4'b0100, 4'b0010, 4'b0001
	};
	// beta = alpha^2: alpha^0, alpha^2, alpha^4, alpha^6.
	localparam logic [GF_M*GF_M-1:0] EVAL_MAT_2 = {
		4'b1100, 4'b0011, 4'b0100, 4'b0001
	};
	// beta = alpha^3: alpha^0, alpha^3, alpha^6, alpha^9.
	localparam logic [GF_M*GF_M-1:0] EVAL_MAT_3 = {
		4'b1010, 4'b1100, 4'b1000, 4'b0001
	};
	// beta = alpha^4: alpha^0, alpha^4, alpha^8, alpha^12.
	localparam logic [GF_M*GF_M-1:0] EVAL_MAT_4 = {
		4'b1111, 4'b0101, 4'b0011, 4'b0001
	};

	// the four syndromes, seen as one word or as field elements.
	// elem[0] holds S1.
	typedef union packed {
		logic [SYN_NUM*GF_M-1:0]   flat;
		gf_elem_t [SYN_NUM-1:0]    elem;
	} syn_bundle_t;

endpackage

// ==== source/bch_syn_ctrl.sv ====
`timescale 1ns/1ps

module bch_syn_ctrl import bch_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic bit_valid,
	input  logic bit_first,
	output logic lfsr_start,
	output logic lfsr_shift,
	output logic eval_capture,
	output logic shuffle_load,
	output logic shuffle_step
);

	// index of the next expected bit within the frame.
	logic [CNT_W-1:0] bit_cnt;
	logic             frame_active;
	logic             last_bit;
	logic [1:0]       step_cnt;

	// a first bit always (re)starts the frame.
	assign lfsr_start = bit_valid & bit_first;
	// later bits only count while a frame is open.
	assign lfsr_shift = bit_valid & ~bit_first & frame_active;
	assign last_bit   = lfsr_shift & (bit_cnt == CNT_W'(CODE_N - 1));

	// frame bit counter.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt      <= '0;
			frame_active <= 1'b0;
		end else if (lfsr_start) begin
			bit_cnt      <= CNT_W'(1);
			frame_active <= 1'b1;
		end else if (last_bit) begin
			// frame complete, further bits are dropped.
			bit_cnt      <= '0;
			frame_active <= 1'b0;
		end else if (lfsr_shift) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// capture one cycle after the last bit, then load behind it.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			eval_capture <= 1'b0;
			shuffle_load <= 1'b0;
		end else begin
			eval_capture <= last_bit;
			shuffle_load <= eval_capture;
		end
	end

	// shuffle phase, SYN_NUM step cycles after the load.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shuffle_step <= 1'b0;
			step_cnt     <= '0;
		end else if (shuffle_load) begin
			shuffle_step <= 1'b1;
			step_cnt     <= '0;
		end else if (shuffle_step) begin
			if (step_cnt == 2'(SYN_NUM - 1)) begin
				shuffle_step <= 1'b0;
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== source/bch_syn_eval.sv ====
`timescale 1ns/1ps

module bch_syn_eval import bch_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        capture,
	input  gf_elem_t    rem_1,
	input  gf_elem_t    rem_3,
	output syn_bundle_t syn,
	output logic        err_detected,
	output logic        syn_valid
);

	syn_bundle_t syn_next;

	// evaluates a remainder polynomial at the point encoded in mat.
	// each set coefficient adds one column.
	function automatic gf_elem_t gf_eval(
		input gf_elem_t                  r,
		input logic [GF_M*GF_M-1:0]      mat
	);
		gf_elem_t acc;
		acc = '0;
		for (int k = 0; k < GF_M; k++) begin
			if (r[k]) begin
				acc ^= mat[k*GF_M +: GF_M];
			end
		end
		return acc;
	endfunction

	// S1, S2 and S4 share m1 as minimal polynomial.
	// S3 needs the m3 remainder.
	always_comb begin
		syn_next.elem[0] = gf_eval(rem_1, EVAL_MAT_1);
		syn_next.elem[1] = gf_eval(rem_1, EVAL_MAT_2);
		syn_next.elem[2] = gf_eval(rem_3, EVAL_MAT_3);
		syn_next.elem[3] = gf_eval(rem_1, EVAL_MAT_4);
	end

	// syndromes hold until the next capture.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			syn          <= '0;
			err_detected <= 1'b0;
		end else if (capture) begin
			syn          <= syn_next;
			// any nonzero syndrome means the word is not a codeword.
			err_detected <= |syn_next.flat;
		end
	end

	// one-cycle strobe with the fresh bundle.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			syn_valid <= 1'b0;
		end else begin
			syn_valid <= capture;
		end
	end

endmodule

// ==== source/bch_syn_lfsr.sv ====
`timescale 1ns/1ps

module bch_syn_lfsr import bch_pkg::*; #(
	// divisor without its leading term.
	parameter gf_elem_t POLY = MIN_POLY_1
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     start,
	input  logic     shift,
	input  logic     data_in,
	output gf_elem_t rem
);

	gf_elem_t rem_next;
	logic     feedback;

	// bit leaving the top of the remainder.
	assign feedback = rem[GF_M-1];

	always_comb begin
		if (start) begin
			rem_next = {{(GF_M-1){1'b0}}, data_in};
		end else begin
			// multiply by x, add the new bit, reduce by the divisor.
			rem_next = {rem[GF_M-2:0], data_in} ^ (POLY & {GF_M{feedback}});
		end
	end

	// remainder of r(x) mod POLY, highest coefficient first.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rem <= '0;
		end else if (start || shift) begin
			rem <= rem_next;
		end
	end

endmodule

// ==== source/bch_syn_shuffle.sv ====
`timescale 1ns/1ps

module bch_syn_shuffle import bch_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        load,
	input  logic        step,
	input  syn_bundle_t syn,
	output gf_elem_t    syn_out,
	output logic [1:0]  syn_out_idx,
	output logic        syn_out_valid
);

	// private copy, so a new capture leaves a running sequence alone.
	gf_elem_t rot [SYN_NUM];

	// rotation register, stage 0 is presented.
	always_ff @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < SYN_NUM; i++) begin
				rot[i] <= syn.elem[i];
			end
		end else if (step) begin
			for (int i = 0; i < SYN_NUM - 1; i++) begin
				rot[i] <= rot[i+1];
			end
			rot[SYN_NUM-1] <= rot[0];
		end
	end

	assign syn_out = rot[0];

	// index and valid follow the rotation.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			syn_out_idx   <= '0;
			syn_out_valid <= 1'b0;
		end else if (load) begin
			syn_out_idx   <= '0;
			syn_out_valid <= 1'b1;
		end else if (step) begin
			syn_out_idx <= syn_out_idx + 1'b1;
			// last syndrome has been shown.
			if (syn_out_idx == 2'(SYN_NUM - 1)) begin
				syn_out_valid <= 1'b0;
			end
		end
	end

endmodule

// ==== source/bch_syn_top.sv ====
`timescale 1ns/1ps

module bch_syn_top import bch_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        bit_valid,
	input  logic        bit_first,
	input  logic        data_in,
	output syn_bundle_t syn,
	output logic        err_detected,
	output logic        syn_valid,
	output gf_elem_t    syn_out,
	output logic [1:0]  syn_out_idx,
	output logic        syn_out_valid
);

	logic     lfsr_start;
	logic     lfsr_shift;
	logic     eval_capture;
	logic     shuffle_load;
	logic     shuffle_step;
	// remainders mod m1 and m3.
	gf_elem_t rem [MIN_NUM];

	bch_syn_ctrl u_ctrl (
		.clk          (clk),
		.arst_n       (arst_n),
		.bit_valid    (bit_valid),
		.bit_first    (bit_first),
		.lfsr_start   (lfsr_start),
		.lfsr_shift   (lfsr_shift),
		.eval_capture (eval_capture),
		.shuffle_load (shuffle_load),
		.shuffle_step (shuffle_step)
	);

	bch_syn_lfsr #(.POLY(MIN_POLY_1)) u_lfsr_1 (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (lfsr_start),
		.shift   (lfsr_shift),
		.data_in (data_in),
		.rem     (rem[0])
	);

	bch_syn_lfsr #(.POLY(MIN_POLY_3)) u_lfsr_3 (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (lfsr_start),
		.shift   (lfsr_shift),
		.data_in (data_in),
		.rem     (rem[1])
	);

	bch_syn_eval u_eval (
		.clk          (clk),
		.arst_n       (arst_n),
		.capture      (eval_capture),
		.rem_1        (rem[0]),
		.rem_3        (rem[1]),
		.syn          (syn),
		.err_detected (err_detected),
		.syn_valid    (syn_valid)
	);

	bch_syn_shuffle u_shuffle (
		.clk           (clk),
		.arst_n        (arst_n),
		.load          (shuffle_load),
		.step          (shuffle_step),
		.syn           (syn),
		.syn_out       (syn_out),
		.syn_out_idx   (syn_out_idx),
		.syn_out_valid (syn_out_valid)
	);

endmodule

// ==== tb/bch_syn_model.svh ====
`ifndef BCH_SYN_MODEL_SVH
`define BCH_SYN_MODEL_SVH

// generator of the BCH(15,7) code, x^8+x^7+x^6+x^4+1.
localparam logic [8:0] GEN_POLY = 9'h1D1;

// shift-and-add product, reduced by x^4+x+1.
function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
	gf_elem_t acc;
	gf_elem_t sh;
	acc = '0;
	sh  = a;
	for (int k = 0; k < GF_M; k++) begin
		if (b[k]) begin
			acc ^= sh;
		end
		if (sh[GF_M-1]) begin
			sh = {sh[GF_M-2:0], 1'b0} ^ PRIM_POLY;
		end else begin
			sh = {sh[GF_M-2:0], 1'b0};
		end
	end
	return acc;
endfunction

// alpha^e by repeated multiplication.
function automatic gf_elem_t gf_pow(input int e);
	gf_elem_t acc;
	acc = 4'b0001;
	for (int k = 0; k < (e % CODE_N); k++) begin
		acc = gf_mul(acc, 4'b0010);
	end
	return acc;
endfunction

// S_j = r(alpha^j), bit i of w is the coefficient of x^i.
function automatic gf_elem_t syndrome_of(input logic [CODE_N-1:0] w, input int j);
	gf_elem_t acc;
	acc = '0;
	for (int i = 0; i < CODE_N; i++) begin
		if (w[i]) begin
			acc ^= gf_pow(i * j);
		end
	end
	return acc;
endfunction

function automatic syn_bundle_t expected_bundle(input logic [CODE_N-1:0] w);
	syn_bundle_t b;
	b.flat = '0;
	for (int j = 1; j <= SYN_NUM; j++) begin
		b.elem[j-1] = syndrome_of(w, j);
	end
	return b;
endfunction

// m(x) * g(x) over GF(2).
function automatic logic [CODE_N-1:0] codeword_of(input logic [6:0] msg);
	logic [CODE_N-1:0] cw;
	cw = '0;
	for (int i = 0; i < 7; i++) begin
		if (msg[i]) begin
			cw ^= {6'b0, GEN_POLY} << i;
		end
	end
	return cw;
endfunction

`endif

// ==== tb/bch_syn_tb.sv ====
`timescale 1ns/1ps

module bch_syn_tb import bch_pkg::*; ();

	// longest wait for any output in clock cycles.
	localparam int TIMEOUT = 40;

	logic        clk;
	logic        arst_n;
	logic        bit_valid;
	logic        bit_first;
	logic        data_in;
	syn_bundle_t syn;
	logic        err_detected;
	logic        syn_valid;
	gf_elem_t    syn_out;
	logic [1:0]  syn_out_idx;
	logic        syn_out_valid;
	integer      seed;

	`include "bch_syn_model.svh"

	bch_syn_top uut (
		.clk           (clk),
		.arst_n        (arst_n),
		.bit_valid     (bit_valid),
		.bit_first     (bit_first),
		.data_in       (data_in),
		.syn           (syn),
		.err_detected  (err_detected),
		.syn_valid     (syn_valid),
		.syn_out       (syn_out),
		.syn_out_idx   (syn_out_idx),
		.syn_out_valid (syn_out_valid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			stop_with_failure();
		end
	endtask

	// inputs change 1 ns after the edge, and outputs are sampled there.
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_idle();
		bit_valid = 1'b0;
		bit_first = 1'b0;
		data_in   = 1'b0;
	endtask

	task automatic send_bit(input logic first, input logic b);
		bit_valid = 1'b1;
		bit_first = first;
		data_in   = b;
		next_cycle();
	endtask

	// highest coefficient first.
	// a nonzero gap adds two idle cycles after every gap-th bit.
	task automatic send_word(input logic [CODE_N-1:0] w, input int gap);
		for (int i = CODE_N - 1; i >= 0; i--) begin
			send_bit(i == CODE_N - 1, w[i]);
			if (gap != 0 && i != 0 && (i % gap) == 0) begin
				drive_idle();
				next_cycle();
				next_cycle();
			end
		end
		drive_idle();
	endtask

	task automatic wait_syn_valid(output int cycles);
		cycles = 0;
		while (syn_valid !== 1'b1) begin
			if (cycles >= TIMEOUT) begin
				$display("timeout, syn_valid never came within %0d cycles", TIMEOUT);
				stop_with_failure();
			end else begin
				next_cycle();
				cycles++;
			end
		end
	endtask

	task automatic wait_syn_out_valid(output int cycles);
		cycles = 0;
		while (syn_out_valid !== 1'b1) begin
			if (cycles >= TIMEOUT) begin
				$display("timeout, syn_out_valid never came within %0d cycles", TIMEOUT);
				stop_with_failure();
			end else begin
				next_cycle();
				cycles++;
			end
		end
	endtask

	// result of one frame, then its four shuffle outputs.
	task automatic check_frame(input logic [CODE_N-1:0] w, output int latency);
		syn_bundle_t exp_b;
		syn_bundle_t got;
		int          cycles;
		exp_b = expected_bundle(w);
		wait_syn_valid(latency);
		got = syn;
		check_equal(32'(got.flat), 32'(exp_b.flat), "syndrome bundle");
		check_equal(32'(err_detected), 32'(exp_b.flat != '0), "err_detected");
		wait_syn_out_valid(cycles);
		check_equal(32'(cycles), 32'd1, "syn_out_valid delay after syn_valid");
		for (int k = 0; k < SYN_NUM; k++) begin
			check_equal(32'(syn_out_valid), 32'd1, "syn_out_valid during sequence");
			check_equal(32'(syn_out_idx), 32'(k), "syn_out_idx");
			check_equal(32'(syn_out), 32'(got.elem[k]), "syn_out against captured bundle");
			next_cycle();
		end
		check_equal(32'(syn_out_valid), 32'd0, "syn_out_valid after four syndromes");
	endtask

	task automatic expect_no_result(input int cycles);
		for (int k = 0; k < cycles; k++) begin
			check_equal(32'(syn_valid), 32'd0, "syn_valid from ignored bits");
			next_cycle();
		end
	endtask

	task automatic test_zero_word();
		int lat;
		send_word('0, 0);
		check_frame('0, lat);
		check_equal(32'(lat), 32'd1, "syn_valid latency after last bit");
	endtask

	task automatic test_codewords();
		logic [6:0] msgs [5] = '{7'h01, 7'h55, 7'h7F, 7'h2A, 7'h13};
		int         lat;
		for (int m = 0; m < 5; m++) begin
			send_word(codeword_of(msgs[m]), 0);
			check_frame(codeword_of(msgs[m]), lat);
			check_equal(32'(syn.flat), 32'd0, "codeword syndromes");
			check_equal(32'(err_detected), 32'd0, "codeword err_detected");
		end
	endtask

	task automatic test_error_words();
		logic [CODE_N-1:0] flips [6] = '{15'h0001, 15'h0080, 15'h4000,
			15'h0202, 15'h1008, 15'h6000};
		logic [CODE_N-1:0] w;
		int                lat;
		for (int e = 0; e < 6; e++) begin
			w = codeword_of(7'h4B) ^ flips[e];
			send_word(w, 0);
			check_frame(w, lat);
			check_equal(32'(err_detected), 32'd1, "err_detected on error word");
			check_equal(32'(syn.elem[1]), 32'(gf_mul(syn.elem[0], syn.elem[0])), "S2 = S1^2");
			check_equal(32'(syn.elem[3]), 32'(gf_mul(syn.elem[1], syn.elem[1])), "S4 = S2^2");
		end
	endtask

	task automatic test_random_words();
		logic [31:0] rnd;
		int          lat;
		for (int n = 0; n < 50; n++) begin
			rnd = $random(seed);
			send_word(rnd[CODE_N-1:0], 0);
			check_frame(rnd[CODE_N-1:0], lat);
		end
	endtask

	task automatic test_back_to_back();
		int lat;
		fork
			begin
				send_word(15'h1234, 0);
				send_word(15'h6ACF, 0);
			end
			check_frame(15'h1234, lat);
		join
		check_frame(15'h6ACF, lat);
	endtask

	task automatic test_idle_gaps();
		int lat;
		send_word(15'h3C5A, 4);
		check_frame(15'h3C5A, lat);
	endtask

	// stray bits of a full frame length go out after reset and again after a frame.
	task automatic test_stray_bits();
		int lat;
		for (int k = 0; k < CODE_N; k++) begin
			send_bit(1'b0, 1'b1);
		end
		drive_idle();
		expect_no_result(20);
		send_word(15'h0F0F, 0);
		check_frame(15'h0F0F, lat);
		for (int k = 0; k < CODE_N; k++) begin
			send_bit(1'b0, 1'b1);
		end
		drive_idle();
		expect_no_result(20);
	endtask

	task automatic test_restart();
		int lat;
		send_bit(1'b1, 1'b1);
		for (int k = 0; k < 6; k++) begin
			send_bit(1'b0, 1'b1);
		end
		send_word(15'h2D71, 0);
		check_frame(15'h2D71, lat);
	endtask

	initial begin
		seed      = 32'h4a0bc04a;
		arst_n    = 1'b0;
		bit_valid = 1'b0;
		bit_first = 1'b0;
		data_in   = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_equal(32'(syn.flat), 32'd0, "syn after reset");
		check_equal(32'(syn_valid), 32'd0, "syn_valid after reset");
		check_equal(32'(syn_out_valid), 32'd0, "syn_out_valid after reset");
		test_stray_bits();
		test_zero_word();
		test_codewords();
		test_error_words();
		test_random_words();
		test_back_to_back();
		test_idle_gaps();
		test_restart();
		$display("Simulation passed");
		$finish;
	end

endmodule
